//--- hw/soc_periph_pkg.sv
// Shared widths, address map, event positions and bus structs; imported by every peripheral
package soc_periph_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////
    localparam int APB_ADDR_W  = 32;
    localparam int APB_DATA_W  = 32;
    localparam int NGPIO       = 32;
    localparam int FC_EVT_W    = 32;
    localparam int FLL_ADDR_W  = 2;
    localparam int SLV_SEL_LSB = 8;
    localparam int SLV_SEL_W   = 4;
    localparam int EVT_SW_W    = 8;
    localparam int REF_CNT_W   = 8;

    typedef logic [APB_ADDR_W-1:0]  apb_addr_t;
    typedef logic [APB_DATA_W-1:0]  apb_data_t;
    typedef logic [NGPIO-1:0]       gpio_vec_t;
    typedef logic [FC_EVT_W-1:0]    fc_events_t;
    typedef logic [FLL_ADDR_W-1:0]  fll_addr_t;
    typedef logic [SLV_SEL_W-1:0]   slv_sel_t;
    typedef logic [SLV_SEL_LSB-1:0] reg_ofs_t;
    typedef logic [EVT_SW_W-1:0]    sw_evt_t;
    typedef logic [REF_CNT_W-1:0]   ref_cnt_t;

    ////////////////////////////////////////////////////////////////////////////
    // Address map
    ////////////////////////////////////////////////////////////////////////////
    // Slave number sits in paddr[SLV_SEL_LSB +: SLV_SEL_W]
    localparam slv_sel_t SLV_GPIO = 4'd0;
    localparam slv_sel_t SLV_FLL  = 4'd1;
    localparam slv_sel_t SLV_EVT  = 4'd2;

    localparam reg_ofs_t GPIO_DIR_OFS    = 8'h00;
    localparam reg_ofs_t GPIO_OUT_OFS    = 8'h04;
    localparam reg_ofs_t GPIO_IN_OFS     = 8'h08;
    localparam reg_ofs_t GPIO_INTEN_OFS  = 8'h0C;
    localparam reg_ofs_t GPIO_STATUS_OFS = 8'h10;

    localparam reg_ofs_t EVT_SW_OFS     = 8'h00;
    localparam reg_ofs_t EVT_REFCNT_OFS = 8'h04;

    // Positions in the fabric controller event vector
    localparam int EVT_REF_EDGE_BIT = 14;
    localparam int EVT_GPIO_BIT     = 15;

    ////////////////////////////////////////////////////////////////////////////
    // Bus structs
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        apb_addr_t paddr;
        apb_data_t pwdata;
        logic      pwrite;
        logic      psel;
        logic      penable;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    // wrn high marks a write
    typedef struct packed {
        logic      req;
        logic      wrn;
        fll_addr_t add;
        apb_data_t data;
    } fll_req_t;

    typedef struct packed {
        logic      ack;
        apb_data_t r_data;
    } fll_rsp_t;

endpackage

//--- hw/periph_apb_decode.sv
// APB slave port decoder; gates psel per peripheral and muxes the selected response back
`timescale 1ns/1ns

module periph_apb_decode (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  soc_periph_pkg::apb_req_t apb_req_i,
    output soc_periph_pkg::apb_rsp_t apb_rsp_o,
    output soc_periph_pkg::apb_req_t gpio_req_o,
    input  soc_periph_pkg::apb_rsp_t gpio_rsp_i,
    output soc_periph_pkg::apb_req_t fll_req_o,
    input  soc_periph_pkg::apb_rsp_t fll_rsp_i,
    output soc_periph_pkg::apb_req_t evt_req_o,
    input  soc_periph_pkg::apb_rsp_t evt_rsp_i
);
    import soc_periph_pkg::*;

    slv_sel_t slv_sel;

    assign slv_sel = apb_req_i.paddr[SLV_SEL_LSB +: SLV_SEL_W];

    // Same request to every slave, only psel differs
    always_comb begin
        gpio_req_o      = apb_req_i;
        fll_req_o       = apb_req_i;
        evt_req_o       = apb_req_i;
        gpio_req_o.psel = apb_req_i.psel && (slv_sel == SLV_GPIO);
        fll_req_o.psel  = apb_req_i.psel && (slv_sel == SLV_FLL);
        evt_req_o.psel  = apb_req_i.psel && (slv_sel == SLV_EVT);
    end

    // Response mux
    always_comb begin
        apb_rsp_o = '0;
        case (slv_sel)
            SLV_GPIO: begin
                apb_rsp_o = gpio_rsp_i;
            end
            SLV_FLL: begin
                apb_rsp_o = fll_rsp_i;
            end
            SLV_EVT: begin
                apb_rsp_o = evt_rsp_i;
            end
            default: begin
                // Unmapped slave answers at once with an error
                apb_rsp_o.prdata  = '0;
                apb_rsp_o.pready  = apb_req_i.psel && apb_req_i.penable;
                apb_rsp_o.pslverr = apb_req_i.psel && apb_req_i.penable;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////
    // Never more than one peripheral selected at a time
    a_one_psel: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({gpio_req_o.psel, fll_req_o.psel, evt_req_o.psel})
    ) else $error("more than one peripheral psel high");

endmodule

//--- hw/periph_gpio.sv
// GPIO peripheral with direction, output, synchronized input and edge interrupt registers
`timescale 1ns/1ns

module periph_gpio (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  soc_periph_pkg::apb_req_t  apb_req_i,
    output soc_periph_pkg::apb_rsp_t  apb_rsp_o,
    input  soc_periph_pkg::gpio_vec_t gpio_in_i,
    output soc_periph_pkg::gpio_vec_t gpio_out_o,
    output soc_periph_pkg::gpio_vec_t gpio_dir_o,
    output logic                      gpio_evt_o
);
    import soc_periph_pkg::*;

    gpio_vec_t dir_q;
    gpio_vec_t out_q;
    gpio_vec_t inten_q;
    gpio_vec_t status_q;
    gpio_vec_t sync1_q;
    gpio_vec_t sync2_q;
    gpio_vec_t prev_q;
    gpio_vec_t rise_en;
    reg_ofs_t  ofs;
    logic      access;
    logic      wr;
    logic      rd_status;
    logic      evt_q;

    assign ofs       = apb_req_i.paddr[SLV_SEL_LSB-1:0];
    assign access    = apb_req_i.psel && apb_req_i.penable;
    assign wr        = access && apb_req_i.pwrite;
    assign rd_status = access && !apb_req_i.pwrite && (ofs == GPIO_STATUS_OFS);

    // Enabled rising edges of the synchronized input
    assign rise_en = sync2_q & ~prev_q & inten_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dir_q    <= '0;
            out_q    <= '0;
            inten_q  <= '0;
            status_q <= '0;
            sync1_q  <= '0;
            sync2_q  <= '0;
            prev_q   <= '0;
            evt_q    <= 1'b0;
        end else begin
            sync1_q <= gpio_in_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
            evt_q   <= |rise_en;
            if (wr && ofs == GPIO_DIR_OFS) begin
                dir_q <= apb_req_i.pwdata;
            end
            if (wr && ofs == GPIO_OUT_OFS) begin
                out_q <= apb_req_i.pwdata;
            end
            if (wr && ofs == GPIO_INTEN_OFS) begin
                inten_q <= apb_req_i.pwdata;
            end
            // Read clears, but an edge in the same cycle still lands
            if (rd_status) begin
                status_q <= rise_en;
            end else begin
                status_q <= status_q | rise_en;
            end
        end
    end

    always_comb begin
        apb_rsp_o         = '0;
        apb_rsp_o.pready  = access;
        apb_rsp_o.pslverr = 1'b0;
        case (ofs)
            GPIO_DIR_OFS:    apb_rsp_o.prdata = dir_q;
            GPIO_OUT_OFS:    apb_rsp_o.prdata = out_q;
            GPIO_IN_OFS:     apb_rsp_o.prdata = sync2_q;
            GPIO_INTEN_OFS:  apb_rsp_o.prdata = inten_q;
            GPIO_STATUS_OFS: apb_rsp_o.prdata = status_q;
            default:         apb_rsp_o.prdata = '0;
        endcase
    end

    assign gpio_out_o = out_q;
    assign gpio_dir_o = dir_q;
    assign gpio_evt_o = evt_q;

    // Status read with no new edge leaves status empty
    a_status_clear: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (rd_status && !(|rise_en)) |=> (status_q == '0)
    ) else $error("gpio status not cleared by read");

endmodule

//--- hw/periph_fll_bridge.sv
// APB to FLL configuration bridge; one four-phase req/ack transfer per APB access
`timescale 1ns/1ns

module periph_fll_bridge (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  soc_periph_pkg::apb_req_t apb_req_i,
    output soc_periph_pkg::apb_rsp_t apb_rsp_o,
    output soc_periph_pkg::fll_req_t fll_req_o,
    input  soc_periph_pkg::fll_rsp_t fll_rsp_i
);
    import soc_periph_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_ACK_LOW,
        DONE
    } fll_state_e;

    fll_state_e state_q;
    fll_state_e state_d;
    fll_addr_t  add_q;
    apb_data_t  wdata_q;
    apb_data_t  rdata_q;
    logic       wrn_q;
    logic       setup;

    // Setup phase starts the transfer so req is up in the first access cycle
    assign setup = apb_req_i.psel && !apb_req_i.penable;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (setup) begin
                    state_d = REQ;
                end
            end
            REQ: begin
                if (fll_rsp_i.ack) begin
                    state_d = WAIT_ACK_LOW;
                end
            end
            WAIT_ACK_LOW: begin
                if (!fll_rsp_i.ack) begin
                    state_d = DONE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Payload registers
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && setup) begin
            add_q   <= apb_req_i.paddr[FLL_ADDR_W+1:2];
            wrn_q   <= apb_req_i.pwrite;
            wdata_q <= apb_req_i.pwdata;
        end
        if (state_q == REQ && fll_rsp_i.ack) begin
            rdata_q <= fll_rsp_i.r_data;
        end
    end

    assign fll_req_o.req  = (state_q == REQ);
    assign fll_req_o.wrn  = wrn_q;
    assign fll_req_o.add  = add_q;
    assign fll_req_o.data = wdata_q;

    assign apb_rsp_o.prdata  = rdata_q;
    assign apb_rsp_o.pready  = (state_q == DONE);
    assign apb_rsp_o.pslverr = 1'b0;

    ////////////////////////////////////////////////////////////////////////////
    // Handshake checks
    ////////////////////////////////////////////////////////////////////////////
    a_req_fall: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $fell(fll_req_o.req) |-> $past(fll_rsp_i.ack)
    ) else $error("fll req dropped before ack");

    a_req_rise: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $rose(fll_req_o.req) |-> !fll_rsp_i.ack
    ) else $error("fll req raised while ack still high");

endmodule

//--- hw/periph_event_map.sv
// Event map; reference clock edge events, edge counter, software events and fc event vector
`timescale 1ns/1ns

module periph_event_map (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  soc_periph_pkg::apb_req_t   apb_req_i,
    output soc_periph_pkg::apb_rsp_t   apb_rsp_o,
    input  logic                       slow_clk_i,
    input  logic                       gpio_evt_i,
    output soc_periph_pkg::fc_events_t fc_events_o
);
    import soc_periph_pkg::*;

    logic     sync1_q;
    logic     sync2_q;
    logic     prev_q;
    logic     ref_rise;
    logic     ref_fall;
    ref_cnt_t cnt_q;
    sw_evt_t  sw_evt_q;
    reg_ofs_t ofs;
    logic     access;
    logic     sw_wr;

    assign ofs    = apb_req_i.paddr[SLV_SEL_LSB-1:0];
    assign access = apb_req_i.psel && apb_req_i.penable;
    assign sw_wr  = access && apb_req_i.pwrite && (ofs == EVT_SW_OFS);

    assign ref_rise = sync2_q && !prev_q;
    assign ref_fall = !sync2_q && prev_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sync1_q  <= 1'b0;
            sync2_q  <= 1'b0;
            prev_q   <= 1'b0;
            cnt_q    <= '0;
            sw_evt_q <= '0;
        end else begin
            sync1_q <= slow_clk_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
            if (ref_rise) begin
                cnt_q <= cnt_q + 1'b1;
            end
            // Software events live for one cycle only
            sw_evt_q <= sw_wr ? apb_req_i.pwdata[EVT_SW_W-1:0] : '0;
        end
    end

    always_comb begin
        fc_events_o                   = '0;
        fc_events_o[EVT_SW_W-1:0]     = sw_evt_q;
        fc_events_o[EVT_REF_EDGE_BIT] = ref_rise || ref_fall;
        fc_events_o[EVT_GPIO_BIT]     = gpio_evt_i;
    end

    // Software event register is write only
    assign apb_rsp_o.prdata  = (ofs == EVT_REFCNT_OFS) ? apb_data_t'(cnt_q) : '0;
    assign apb_rsp_o.pready  = access;
    assign apb_rsp_o.pslverr = 1'b0;

    a_sw_pulse: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        ((|fc_events_o[EVT_SW_W-1:0]) && !sw_wr) |=> (fc_events_o[EVT_SW_W-1:0] == '0)
    ) else $error("software event held for more than one cycle");

endmodule

//--- hw/soc_periph_top.sv
// Peripheral subsystem top; APB decoder feeding GPIO, FLL bridge and event map
`timescale 1ns/1ns

module soc_periph_top (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  soc_periph_pkg::apb_req_t   apb_req_i,
    output soc_periph_pkg::apb_rsp_t   apb_rsp_o,
    input  logic                       slow_clk_i,
    input  soc_periph_pkg::gpio_vec_t  gpio_in_i,
    output soc_periph_pkg::gpio_vec_t  gpio_out_o,
    output soc_periph_pkg::gpio_vec_t  gpio_dir_o,
    output soc_periph_pkg::fll_req_t   fll_req_o,
    input  soc_periph_pkg::fll_rsp_t   fll_rsp_i,
    output soc_periph_pkg::fc_events_t fc_events_o
);
    import soc_periph_pkg::*;

    apb_req_t gpio_req;
    apb_req_t fll_req;
    apb_req_t evt_req;
    apb_rsp_t gpio_rsp;
    apb_rsp_t fll_rsp;
    apb_rsp_t evt_rsp;
    logic     gpio_evt;

    ////////////////////////////////////////////////////////////////////////////
    // Bus decode
    ////////////////////////////////////////////////////////////////////////////
    periph_apb_decode u_apb_decode (
        .clk_i      ( clk_i     ),
        .rst_n_i    ( rst_n_i   ),
        .apb_req_i  ( apb_req_i ),
        .apb_rsp_o  ( apb_rsp_o ),
        .gpio_req_o ( gpio_req  ),
        .gpio_rsp_i ( gpio_rsp  ),
        .fll_req_o  ( fll_req   ),
        .fll_rsp_i  ( fll_rsp   ),
        .evt_req_o  ( evt_req   ),
        .evt_rsp_i  ( evt_rsp   )
    );

    ////////////////////////////////////////////////////////////////////////////
    // Peripherals
    ////////////////////////////////////////////////////////////////////////////
    periph_gpio u_gpio (
        .clk_i      ( clk_i      ),
        .rst_n_i    ( rst_n_i    ),
        .apb_req_i  ( gpio_req   ),
        .apb_rsp_o  ( gpio_rsp   ),
        .gpio_in_i  ( gpio_in_i  ),
        .gpio_out_o ( gpio_out_o ),
        .gpio_dir_o ( gpio_dir_o ),
        .gpio_evt_o ( gpio_evt   )
    );

    periph_fll_bridge u_fll_bridge (
        .clk_i     ( clk_i     ),
        .rst_n_i   ( rst_n_i   ),
        .apb_req_i ( fll_req   ),
        .apb_rsp_o ( fll_rsp   ),
        .fll_req_o ( fll_req_o ),
        .fll_rsp_i ( fll_rsp_i )
    );

    // GPIO interrupt goes out through the fc event vector
    periph_event_map u_event_map (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .apb_req_i   ( evt_req     ),
        .apb_rsp_o   ( evt_rsp     ),
        .slow_clk_i  ( slow_clk_i  ),
        .gpio_evt_i  ( gpio_evt    ),
        .fc_events_o ( fc_events_o )
    );

endmodule

//--- verif/tb_soc_periph_tasks.svh
// Testbench helpers for the peripheral subsystem; APB access tasks, value check and LFSR bits
`ifndef TB_SOC_PERIPH_TASKS_SVH
`define TB_SOC_PERIPH_TASKS_SVH

// Galois LFSR, one step per bit taken
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
        v      = {v[30:0], lfsr_q[0]};
        lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return v;
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("ERROR %s got 0x%08h expected 0x%08h", name, got, exp);
        stop_with_failure("value mismatch");
    end
endtask

// Called right after a falling edge, returns right after a falling edge
// Response is sampled 1 ns after the falling edge, once the decode has settled
task automatic apb_write(input logic [31:0] addr, input logic [31:0] data, output logic err);
    apb_req         = '0;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    apb_req.pwrite  = 1'b1;
    apb_req.psel    = 1'b1;
    @(negedge clk_i);
    apb_req.penable = 1'b1;
    #1;
    while (!apb_rsp.pready) begin
        @(negedge clk_i);
        #1;
    end
    // Access ends at the next rising edge
    err             = apb_rsp.pslverr;
    last_wr_cycle   = cycle_cnt;
    @(negedge clk_i);
    apb_req         = '0;
endtask

task automatic apb_read(input logic [31:0] addr, output logic [31:0] data, output logic err);
    apb_req         = '0;
    apb_req.paddr   = addr;
    apb_req.psel    = 1'b1;
    @(negedge clk_i);
    apb_req.penable = 1'b1;
    #1;
    while (!apb_rsp.pready) begin
        @(negedge clk_i);
        #1;
    end
    data            = apb_rsp.prdata;
    err             = apb_rsp.pslverr;
    @(negedge clk_i);
    apb_req         = '0;
endtask

`endif

//--- verif/tb_soc_periph.sv
// Testbench top for the peripheral subsystem; runs a stimulus table against the DUT and an FLL model
`timescale 1ns/1ns

module tb_soc_periph;
    import soc_periph_pkg::*;

    localparam int OP_WR     = 0;
    localparam int OP_RD     = 1;
    localparam int OP_SETIN  = 2;
    localparam int OP_TOGGLE = 3;
    localparam int OP_WAIT   = 4;
    localparam int OP_OBS    = 5;

    // Observed values for OP_OBS, FLL model registers from OBS_FLL_REG up
    localparam int OBS_DIR         = 0;
    localparam int OBS_OUT         = 1;
    localparam int OBS_GPIO_PULSES = 2;
    localparam int OBS_EDGE_PULSES = 3;
    localparam int OBS_SW_PULSES   = 4;
    localparam int OBS_SW_VALUE    = 5;
    localparam int OBS_FLL_REG     = 8;

    typedef struct packed {
        logic [2:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
        logic        err;
    } entry_t;

    logic        clk_i;
    logic        rst_n_i;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        slow_clk;
    gpio_vec_t   gpio_in;
    gpio_vec_t   gpio_out;
    gpio_vec_t   gpio_dir;
    fll_req_t    fll_req;
    fll_rsp_t    fll_rsp;
    fc_events_t  fc_events;
    logic [31:0] lfsr_q;
    logic [31:0] fll_regs [4];
    entry_t      table_q [$];
    int          cycle_cnt;
    int          timeout_cycles;
    int          last_wr_cycle;
    int          edge_pulses;
    int          gpio_pulses;
    int          sw_pulses;
    logic [7:0]  sw_value;
    int          error_count;

    task automatic stop_with_failure(input string why);
        error_count++;
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    `include "tb_soc_periph_tasks.svh"

    soc_periph_top u_dut (
        .clk_i       ( clk_i     ),
        .rst_n_i     ( rst_n_i   ),
        .apb_req_i   ( apb_req   ),
        .apb_rsp_o   ( apb_rsp   ),
        .slow_clk_i  ( slow_clk  ),
        .gpio_in_i   ( gpio_in   ),
        .gpio_out_o  ( gpio_out  ),
        .gpio_dir_o  ( gpio_dir  ),
        .fll_req_o   ( fll_req   ),
        .fll_rsp_i   ( fll_rsp   ),
        .fc_events_o ( fc_events )
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #5 clk_i = ~clk_i;
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (timeout_cycles > 0 && cycle_cnt > timeout_cycles) begin
            stop_with_failure("timeout: the run took longer than the cycle limit");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Event monitor, sampled mid-cycle
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            if (fc_events[EVT_REF_EDGE_BIT]) edge_pulses++;
            if (fc_events[EVT_GPIO_BIT]) gpio_pulses++;
            if (fc_events[7:0] != '0) begin
                sw_pulses++;
                sw_value = fc_events[7:0];
                // Pulse belongs to the cycle right after the write access
                check_value("sw_evt_cycle", cycle_cnt, last_wr_cycle + 1);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // FLL clock generator model
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        int n;
        fll_rsp = '0;
        forever begin
            @(negedge clk_i);
            if (fll_req.req) begin
                n = 1 + int'(take_bits(2));
                repeat (n) begin
                    @(negedge clk_i);
                    if (!fll_req.req) stop_with_failure("FLL req dropped before ack was raised");
                end
                if (fll_req.wrn) begin
                    fll_regs[fll_req.add] = fll_req.data;
                end else begin
                    fll_rsp.r_data = fll_regs[fll_req.add];
                end
                fll_rsp.ack = 1'b1;
                while (fll_req.req) begin
                    @(negedge clk_i);
                end
                n = 1 + int'(take_bits(2));
                repeat (n) begin
                    @(negedge clk_i);
                    if (fll_req.req) stop_with_failure("FLL req raised again while ack was high");
                end
                fll_rsp.ack = 1'b0;
            end
        end
    end

    task automatic add(input int op, input logic [31:0] addr, input logic [31:0] data,
                       input logic [31:0] exp, input logic err);
        entry_t e;
        e.op   = op[2:0];
        e.addr = addr;
        e.data = data;
        e.exp  = exp;
        e.err  = err;
        table_q.push_back(e);
    endtask

    function automatic logic [31:0] observe(input logic [31:0] sel);
        case (sel)
            OBS_DIR:         return gpio_dir;
            OBS_OUT:         return gpio_out;
            OBS_GPIO_PULSES: return gpio_pulses;
            OBS_EDGE_PULSES: return edge_pulses;
            OBS_SW_PULSES:   return sw_pulses;
            OBS_SW_VALUE:    return {24'h0, sw_value};
            default:         return fll_regs[sel[1:0]];
        endcase
    endfunction

    initial begin
        entry_t      e;
        logic [31:0] rdata;
        logic        err;
        int          periods;
        int          i;
        apb_req = '0;
        slow_clk = 1'b0;
        gpio_in = '0;
        rst_n_i = 1'b0;
        lfsr_q = 32'haf61;
        cycle_cnt = 0;
        timeout_cycles = 0;
        last_wr_cycle = -2;
        edge_pulses = 0;
        gpio_pulses = 0;
        sw_pulses = 0;
        sw_value = '0;
        error_count = 0;
        periods = 0;
        for (i = 0; i < 4; i++) fll_regs[i] = '0;

        // GPIO registers, pins, input sync and interrupt
        add(OP_WR, 32'h000, 32'hffff_0000, 0, 0);
        add(OP_WR, 32'h004, 32'h0000_a5a5, 0, 0);
        add(OP_RD, 32'h000, 0, 32'hffff_0000, 0);
        add(OP_RD, 32'h004, 0, 32'h0000_a5a5, 0);
        add(OP_OBS, 0, OBS_DIR, 32'hffff_0000, 0);
        add(OP_OBS, 0, OBS_OUT, 32'h0000_a5a5, 0);
        add(OP_SETIN, 0, 32'h1234_0000, 0, 0);
        add(OP_WAIT, 0, 4, 0, 0);
        add(OP_RD, 32'h008, 0, 32'h1234_0000, 0);
        add(OP_WR, 32'h00C, 32'h0000_0008, 0, 0);
        add(OP_SETIN, 0, 32'h1234_0008, 0, 0);
        add(OP_WAIT, 0, 4, 0, 0);
        add(OP_RD, 32'h010, 0, 32'h0000_0008, 0);
        add(OP_RD, 32'h010, 0, 32'h0000_0000, 0);
        add(OP_OBS, 0, OBS_GPIO_PULSES, 1, 0);
        // FLL registers through the handshake
        for (i = 0; i < 4; i++) add(OP_WR, 32'h100 + 4 * i, 32'hcafe_0000 + i * 32'h1111, 0, 0);
        for (i = 0; i < 4; i++) add(OP_RD, 32'h100 + 4 * i, 0, 32'hcafe_0000 + i * 32'h1111, 0);
        for (i = 0; i < 4; i++) add(OP_OBS, 0, OBS_FLL_REG + i, 32'hcafe_0000 + i * 32'h1111, 0);
        // Software events and reference clock edges
        add(OP_WR, 32'h200, 32'h0000_00a5, 0, 0);
        add(OP_WAIT, 0, 3, 0, 0);
        add(OP_OBS, 0, OBS_SW_PULSES, 1, 0);
        add(OP_OBS, 0, OBS_SW_VALUE, 32'ha5, 0);
        periods += 3;
        add(OP_TOGGLE, 0, 3, 0, 0);
        add(OP_RD, 32'h204, 0, periods % 256, 0);
        add(OP_OBS, 0, OBS_EDGE_PULSES, 2 * periods, 0);
        periods += 5;
        add(OP_TOGGLE, 0, 5, 0, 0);
        add(OP_RD, 32'h204, 0, periods % 256, 0);
        add(OP_OBS, 0, OBS_EDGE_PULSES, 2 * periods, 0);
        // Unmapped slave 5
        add(OP_RD, 32'h500, 0, 0, 1);
        add(OP_WR, 32'h500, 32'hffff_ffff, 0, 1);
        add(OP_RD, 32'h000, 0, 32'hffff_0000, 0);
        add(OP_RD, 32'h004, 0, 32'h0000_a5a5, 0);
        add(OP_RD, 32'h00C, 0, 32'h0000_0008, 0);
        add(OP_RD, 32'h100, 0, 32'hcafe_0000, 0);
        add(OP_OBS, 0, OBS_SW_PULSES, 1, 0);
        timeout_cycles = table_q.size() * 40 + 8;

        repeat (8) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);
        foreach (table_q[k]) begin
            e = table_q[k];
            case (e.op)
                OP_WR: begin
                    apb_write(e.addr, e.data, err);
                    check_value("pslverr", {31'h0, err}, {31'h0, e.err});
                end
                OP_RD: begin
                    apb_read(e.addr, rdata, err);
                    check_value("prdata", rdata, e.exp);
                    check_value("pslverr", {31'h0, err}, {31'h0, e.err});
                end
                OP_SETIN: gpio_in = e.data;
                OP_TOGGLE: begin
                    // Each level held 4 cycles so the synchronizer sees it
                    repeat (e.data) begin
                        slow_clk = 1'b1;
                        repeat (4) @(negedge clk_i);
                        slow_clk = 1'b0;
                        repeat (4) @(negedge clk_i);
                    end
                end
                OP_WAIT: repeat (e.data) @(negedge clk_i);
                default: check_value("observed", observe(e.data), e.exp);
            endcase
        end

        if (error_count == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("tests failed");
            $fatal(1);
        end
    end

endmodule

//--- soc_periph.f
hw/soc_periph_pkg.sv
hw/periph_apb_decode.sv
hw/periph_gpio.sv
hw/periph_fll_bridge.sv
hw/periph_event_map.sv
hw/soc_periph_top.sv
+incdir+verif
verif/tb_soc_periph.sv

//--- Makefile
# Verilator build for the peripheral subsystem testbench

VERILATOR ?= verilator
FLAGS     ?= --timing --assert -j 0
TOP       ?= tb_soc_periph
FILELIST  ?= soc_periph.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		exit 0; \
	else \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
